// File: hdl/ncpu_pkg.sv
// Shared types for the execute slice; lane count is limited to MAX_LANES by rr_pick
package ncpu_pkg;

   localparam int DATA_W    = 32;
   localparam int INSN_W    = 32;
   localparam int REG_AW    = 5;
   localparam int NUM_REGS  = 2 ** REG_AW;
   localparam int MAX_LANES = 16;

   // Opcode field, insn bits 5..0
   typedef enum logic [5:0] {
      OP_AND   = 6'h00,
      OP_AND_I = 6'h01,
      OP_OR    = 6'h02,
      OP_OR_I  = 6'h03,
      OP_XOR   = 6'h04,
      OP_XOR_I = 6'h05,
      OP_LSL   = 6'h06,
      OP_LSL_I = 6'h07,
      OP_LSR   = 6'h08,
      OP_LSR_I = 6'h09,
      OP_ADD   = 6'h0c,
      OP_ADD_I = 6'h0d,
      OP_SUB   = 6'h0e,
      OP_MUL   = 6'h0f,
      OP_MHI   = 6'h18
   } opcode_e;

   typedef enum logic [3:0] {
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_LSL,
      ALU_LSR,
      ALU_ADD,
      ALU_SUB,
      ALU_MUL,
      ALU_PASS
   } alu_op_e;

   typedef enum logic [1:0] {
      IDLE,
      MUL_RUN,
      DONE
   } lane_state_e;

   typedef struct packed {
      alu_op_e           alu_op;
      logic [DATA_W-1:0] opa;
      logic [DATA_W-1:0] opb;
      logic [REG_AW-1:0] rd;
   } dec_op_t;

   // Round-robin pick, first set bit after 'last'; returns 'last' when req is empty
   function automatic int rr_pick(input logic [MAX_LANES-1:0] req,
                                  input int last,
                                  input int n);
      int idx;
      int pick;
      pick = last;
      // Walk down so the nearest candidate wins
      for (int k = MAX_LANES; k >= 1; k--) begin
         if (k <= n) begin
            idx = last + k;
            if (idx >= n) begin
               idx = idx - n;
            end
            if (req[idx]) begin
               pick = idx;
            end
         end
      end
      return pick;
   endfunction

endpackage

// File: hdl/ncpu_if.sv
// Valid/ready bundles; payload must hold steady while valid is high and ready is low
`timescale 1ns/1ns

interface ncpu_op_if;
   import ncpu_pkg::*;

   logic    valid;
   logic    ready;
   dec_op_t op;

   modport src (output valid, output op, input ready);
   modport dst (input valid, input op, output ready);
endinterface

interface ncpu_res_if;
   import ncpu_pkg::*;

   logic              valid;
   logic              ready;
   logic [REG_AW-1:0] rd;
   logic [DATA_W-1:0] data;

   modport src (output valid, output rd, output data, input ready);
   modport dst (input valid, input rd, input data, output ready);
endinterface

// Two combinational read ports, no handshake
interface ncpu_rf_rd_if;
   import ncpu_pkg::*;

   logic [REG_AW-1:0] rs1_addr;
   logic [DATA_W-1:0] rs1_data;
   logic [REG_AW-1:0] rs2_addr;
   logic [DATA_W-1:0] rs2_data;

   modport req (
      output rs1_addr,
      output rs2_addr,
      input  rs1_data,
      input  rs2_data
   );
   modport rf (
      input  rs1_addr,
      input  rs2_addr,
      output rs1_data,
      output rs2_data
   );
endinterface

// File: hdl/ncpu_regfile.sv
// Register file without write-to-read bypass; a write is visible the cycle after it
`timescale 1ns/1ns

module ncpu_regfile (
   input  logic                        clk_i,
   input  logic                        arst_n_i,
   ncpu_rf_rd_if.rf                    rd,
   input  logic                        we_i,
   input  logic [ncpu_pkg::REG_AW-1:0] waddr_i,
   input  logic [ncpu_pkg::DATA_W-1:0] wdata_i
);
   import ncpu_pkg::*;

   // r0 has no storage
   logic [DATA_W-1:0] regs [1:NUM_REGS-1];

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 1; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we_i && (waddr_i != '0)) begin
         regs[waddr_i] <= wdata_i;
      end
   end

   assign rd.rs1_data = (rd.rs1_addr == '0) ? '0 : regs[rd.rs1_addr];
   assign rd.rs2_data = (rd.rs2_addr == '0) ? '0 : regs[rd.rs2_addr];

endmodule

// File: hdl/ncpu_idu.sv
// Decoder with scoreboard; insn_i must stay stable while insn_valid_i waits for ready
`timescale 1ns/1ns

module ncpu_idu (
   input  logic                        clk_i,
   input  logic                        arst_n_i,
   input  logic                        insn_valid_i,
   input  logic [ncpu_pkg::INSN_W-1:0] insn_i,
   output logic                        insn_ready_o,
   output logic                        illegal_o,
   ncpu_rf_rd_if.req                   rf,
   ncpu_op_if.src                      op,
   input  logic                        wb_we_i,
   input  logic [ncpu_pkg::REG_AW-1:0] wb_addr_i
);
   import ncpu_pkg::*;

   logic [5:0]          f_opcode;
   logic [REG_AW-1:0]   f_rd;
   logic [REG_AW-1:0]   f_rs1;
   logic [REG_AW-1:0]   f_rs2;
   logic [15:0]         f_imm16;

   logic                legal;
   logic                use_imm;
   logic                imm_signed;
   logic                is_mhi;
   alu_op_e             alu_op;
   logic [DATA_W-1:0]   imm_ext;
   dec_op_t             dec_op;

   logic [NUM_REGS-1:0] pending_q;
   logic [NUM_REGS-1:0] set_mask;
   logic [NUM_REGS-1:0] clr_mask;
   logic                conflict;
   logic                issue;
   logic                accept;
   logic                run_q;
   logic                op_valid_q;
   dec_op_t             op_q;
   logic                illegal_q;

   assign f_opcode = insn_i[5:0];
   assign f_rd     = insn_i[10:6];
   assign f_rs1    = insn_i[15:11];
   assign f_rs2    = insn_i[20:16];
   assign f_imm16  = insn_i[31:16];

   assign rf.rs1_addr = f_rs1;
   assign rf.rs2_addr = f_rs2;

   always_comb begin
      legal  = 1'b1;
      alu_op = ALU_PASS;
      case (f_opcode)
         OP_AND, OP_AND_I: alu_op = ALU_AND;
         OP_OR,  OP_OR_I:  alu_op = ALU_OR;
         OP_XOR, OP_XOR_I: alu_op = ALU_XOR;
         OP_LSL, OP_LSL_I: alu_op = ALU_LSL;
         OP_LSR, OP_LSR_I: alu_op = ALU_LSR;
         OP_ADD, OP_ADD_I: alu_op = ALU_ADD;
         OP_SUB:           alu_op = ALU_SUB;
         OP_MUL:           alu_op = ALU_MUL;
         OP_MHI:           alu_op = ALU_PASS;
         default:          legal  = 1'b0;
      endcase
   end

   assign use_imm    = f_opcode inside {OP_AND_I, OP_OR_I, OP_XOR_I, OP_LSL_I,
                                        OP_LSR_I, OP_ADD_I, OP_MHI};
   assign imm_signed = f_opcode inside {OP_AND_I, OP_XOR_I, OP_ADD_I};
   assign is_mhi     = (f_opcode == OP_MHI);

   // Shift immediates go through zero-extended, the lane keeps the low bits
   assign imm_ext = is_mhi     ? {f_imm16, 16'h0000} :
                    imm_signed ? {{(DATA_W-16){f_imm16[15]}}, f_imm16} :
                                 {{(DATA_W-16){1'b0}}, f_imm16};

   assign dec_op.alu_op = alu_op;
   assign dec_op.opa    = rf.rs1_data;
   assign dec_op.opb    = use_imm ? imm_ext : rf.rs2_data;
   assign dec_op.rd     = f_rd;

   // MHI reads no register, immediate forms skip rs2
   assign conflict = legal & ((pending_q[f_rs1] & ~is_mhi) |
                              (pending_q[f_rs2] & ~use_imm) |
                              pending_q[f_rd]);

   // rd of zero makes the insn a no-op
   assign issue = legal & (f_rd != '0);

   assign insn_ready_o = run_q & (~op_valid_q | op.ready) & ~conflict;
   assign accept       = insn_valid_i & insn_ready_o;

   assign set_mask = (accept && issue) ? (NUM_REGS'(1) << f_rd) : '0;
   assign clr_mask = wb_we_i ? (NUM_REGS'(1) << wb_addr_i) : '0;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         run_q      <= 1'b0;
         op_valid_q <= 1'b0;
         illegal_q  <= 1'b0;
         pending_q  <= '0;
      end else begin
         run_q     <= 1'b1;
         illegal_q <= accept & ~legal;
         pending_q <= (pending_q & ~clr_mask) | set_mask;
         if (op_valid_q && op.ready) begin
            op_valid_q <= 1'b0;
         end
         if (accept && issue) begin
            op_valid_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept && issue) begin
         op_q <= dec_op;
      end
   end

   assign op.valid  = op_valid_q;
   assign op.op     = op_q;
   assign illegal_o = illegal_q;

endmodule

// File: hdl/ncpu_dispatch.sv
// Combinational dispatcher; NUM_LANES from 1 to MAX_LANES
`timescale 1ns/1ns

module ncpu_dispatch #(
   parameter int NUM_LANES = 3
) (
   input  logic   clk_i,
   input  logic   arst_n_i,
   ncpu_op_if.dst in,
   ncpu_op_if.src out [NUM_LANES]
);
   import ncpu_pkg::*;

   localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

   logic [NUM_LANES-1:0] lane_rdy;
   logic [NUM_LANES-1:0] grant;
   logic [PTR_W-1:0]     pick;
   logic [PTR_W-1:0]     last_q;

   for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
      assign lane_rdy[i]  = out[i].ready;
      assign out[i].valid = in.valid & grant[i];
      assign out[i].op    = in.op;
   end

   // Search starts at the lane after the previous grant
   assign pick  = PTR_W'(rr_pick(MAX_LANES'(lane_rdy), int'(last_q), NUM_LANES));
   assign grant = (|lane_rdy) ? (NUM_LANES'(1) << pick) : '0;

   // No idle lane holds the decoder
   assign in.ready = |lane_rdy;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         last_q <= PTR_W'(NUM_LANES - 1);
      end else if (in.valid && in.ready) begin
         last_q <= pick;
      end
   end

endmodule

// File: hdl/ncpu_alu_lane.sv
// One lane, one op at a time; MUL takes 7 extra cycles, result waits in DONE for ready
`timescale 1ns/1ns

module ncpu_alu_lane (
   input  logic    clk_i,
   input  logic    arst_n_i,
   ncpu_op_if.dst  op,
   ncpu_res_if.src res
);
   import ncpu_pkg::*;

   localparam int SH_W = $clog2(DATA_W);

   lane_state_e       state_q;
   logic [2:0]        cnt_q;
   logic [DATA_W-1:0] res_q;
   logic [DATA_W-1:0] mcand_q;
   logic [DATA_W-1:0] mplier_q;
   logic [DATA_W-1:0] alu_out;
   logic [REG_AW-1:0] rd_q;
   logic              start;

   assign op.ready = (state_q == IDLE);
   assign start    = op.valid & op.ready;

   always_comb begin
      case (op.op.alu_op)
         ALU_AND: alu_out = op.op.opa & op.op.opb;
         ALU_OR:  alu_out = op.op.opa | op.op.opb;
         ALU_XOR: alu_out = op.op.opa ^ op.op.opb;
         ALU_LSL: alu_out = op.op.opa << op.op.opb[SH_W-1:0];
         ALU_LSR: alu_out = op.op.opa >> op.op.opb[SH_W-1:0];
         ALU_ADD: alu_out = op.op.opa + op.op.opb;
         ALU_SUB: alu_out = op.op.opa - op.op.opb;
         // First nibble of the multiplier
         ALU_MUL: alu_out = op.op.opa * DATA_W'(op.op.opb[3:0]);
         default: alu_out = op.op.opb;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            IDLE: begin
               if (op.valid) begin
                  cnt_q   <= 3'd7;
                  state_q <= (op.op.alu_op == ALU_MUL) ? MUL_RUN : DONE;
               end
            end
            MUL_RUN: begin
               cnt_q <= cnt_q - 3'd1;
               if (cnt_q == 3'd1) begin
                  state_q <= DONE;
               end
            end
            DONE: begin
               if (res.ready) begin
                  state_q <= IDLE;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Remaining 7 nibbles accumulate here, low 32 bits only
   always_ff @(posedge clk_i) begin
      if (start) begin
         res_q    <= alu_out;
         rd_q     <= op.op.rd;
         mcand_q  <= op.op.opa << 4;
         mplier_q <= op.op.opb >> 4;
      end else if (state_q == MUL_RUN) begin
         res_q    <= res_q + mcand_q * DATA_W'(mplier_q[3:0]);
         mcand_q  <= mcand_q << 4;
         mplier_q <= mplier_q >> 4;
      end
   end

   assign res.valid = (state_q == DONE);
   assign res.rd    = rd_q;
   assign res.data  = res_q;

endmodule

// File: hdl/ncpu_wb_arb.sv
// Writeback arbiter, one grant per cycle; outputs are one-cycle pulses with no back-pressure
`timescale 1ns/1ns

module ncpu_wb_arb #(
   parameter int NUM_LANES = 3
) (
   input  logic                        clk_i,
   input  logic                        arst_n_i,
   ncpu_res_if.dst                     res [NUM_LANES],
   output logic                        we_o,
   output logic [ncpu_pkg::REG_AW-1:0] waddr_o,
   output logic [ncpu_pkg::DATA_W-1:0] wdata_o
);
   import ncpu_pkg::*;

   localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

   logic [NUM_LANES-1:0] req;
   logic [REG_AW-1:0]    rd_a   [NUM_LANES];
   logic [DATA_W-1:0]    data_a [NUM_LANES];
   logic [PTR_W-1:0]     pick;
   logic [PTR_W-1:0]     last_q;
   logic                 any_req;

   for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
      assign req[i]       = res[i].valid;
      assign rd_a[i]      = res[i].rd;
      assign data_a[i]    = res[i].data;
      assign res[i].ready = any_req & (pick == PTR_W'(i));
   end

   assign any_req = |req;
   assign pick    = PTR_W'(rr_pick(MAX_LANES'(req), int'(last_q), NUM_LANES));

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         we_o   <= 1'b0;
         last_q <= PTR_W'(NUM_LANES - 1);
      end else begin
         we_o <= any_req;
         if (any_req) begin
            last_q <= pick;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (any_req) begin
         waddr_o <= rd_a[pick];
         wdata_o <= data_a[pick];
      end
   end

endmodule

// File: hdl/ncpu_exec_top.sv
// Execute slice top; writeback outputs cannot be stalled, wb_valid_o marks each register write
`timescale 1ns/1ns

module ncpu_exec_top #(
   parameter int NUM_LANES = 3
) (
   input  logic                        clk_i,
   input  logic                        arst_n_i,
   input  logic                        insn_valid_i,
   input  logic [ncpu_pkg::INSN_W-1:0] insn_i,
   output logic                        insn_ready_o,
   output logic                        wb_valid_o,
   output logic [ncpu_pkg::REG_AW-1:0] wb_addr_o,
   output logic [ncpu_pkg::DATA_W-1:0] wb_data_o,
   output logic                        illegal_o
);

   ncpu_rf_rd_if rf_rd ();
   ncpu_op_if    issue ();
   ncpu_op_if    lane_op  [NUM_LANES] ();
   ncpu_res_if   lane_res [NUM_LANES] ();

   // Writeback port doubles as the regfile write and scoreboard clear
   ncpu_regfile u_regfile (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .rd       (rf_rd),
      .we_i     (wb_valid_o),
      .waddr_i  (wb_addr_o),
      .wdata_i  (wb_data_o)
   );

   ncpu_idu u_idu (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .insn_valid_i (insn_valid_i),
      .insn_i       (insn_i),
      .insn_ready_o (insn_ready_o),
      .illegal_o    (illegal_o),
      .rf           (rf_rd),
      .op           (issue),
      .wb_we_i      (wb_valid_o),
      .wb_addr_i    (wb_addr_o)
   );

   ncpu_dispatch #(.NUM_LANES(NUM_LANES)) u_dispatch (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .in       (issue),
      .out      (lane_op)
   );

   for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
      ncpu_alu_lane u_lane (
         .clk_i    (clk_i),
         .arst_n_i (arst_n_i),
         .op       (lane_op[i]),
         .res      (lane_res[i])
      );
   end

   ncpu_wb_arb #(.NUM_LANES(NUM_LANES)) u_wb_arb (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .res      (lane_res),
      .we_o     (wb_valid_o),
      .waddr_o  (wb_addr_o),
      .wdata_o  (wb_data_o)
   );

endmodule

// File: verif/ncpu_exec_chk.sv
// Port-level assertions for ncpu_exec_top, attached by bind; needs assertion support enabled
`timescale 1ns/1ns

module ncpu_exec_chk (
   input logic                        clk_i,
   input logic                        arst_n_i,
   input logic                        wb_valid_i,
   input logic [ncpu_pkg::REG_AW-1:0] wb_addr_i,
   input logic [ncpu_pkg::DATA_W-1:0] wb_data_i,
   input logic                        illegal_i
);

   // r0 is never a writeback target
   a_no_wb_r0: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      wb_valid_i |-> (wb_addr_i != '0))
      else $error("writeback issued to r0");

   a_quiet_in_reset: assert property (@(posedge clk_i)
      !arst_n_i |-> (!wb_valid_i && !illegal_i))
      else $error("writeback or illegal pulse while in reset");

   a_wb_data_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      wb_valid_i |-> !$isunknown(wb_data_i))
      else $error("writeback data has unknown bits");

endmodule

bind ncpu_exec_top ncpu_exec_chk u_chk (
   .clk_i      (clk_i),
   .arst_n_i   (arst_n_i),
   .wb_valid_i (wb_valid_o),
   .wb_addr_i  (wb_addr_o),
   .wb_data_i  (wb_data_o),
   .illegal_i  (illegal_o)
);

// File: verif/ncpu_exec_tb.sv
// Table-driven testbench for ncpu_exec_top with 3 lanes; all registers read zero after reset
`timescale 1ns/1ns

module ncpu_exec_tb;
   import ncpu_pkg::*;

   localparam int TIMEOUT = 200;

   typedef struct packed {
      int          id;
      logic [31:0] insn;
      logic        wb;
      logic        ill;
      logic [4:0]  rd;
      logic [31:0] val;
   } entry_t;

   logic        clk = 1'b0;
   logic        arst_n_i;
   logic        insn_valid_i;
   logic [31:0] insn_i;
   logic        insn_ready_o;
   logic        wb_valid_o;
   logic [4:0]  wb_addr_o;
   logic [31:0] wb_data_o;
   logic        illegal_o;

   entry_t      table_q [$];
   logic [36:0] exp_wb [$];
   logic [4:0]  wb_log [$];
   logic [31:0] model_regs [32];
   logic [31:0] lfsr;
   int          err_cnt = 0;
   int          test_start_err = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          ill_seen = 0;
   int          ill_exp = 0;
   logic [5:0]  short_ops [14] = '{OP_AND, OP_AND_I, OP_OR, OP_OR_I, OP_XOR, OP_XOR_I,
                                   OP_LSL, OP_LSL_I, OP_LSR, OP_LSR_I, OP_ADD, OP_ADD_I,
                                   OP_SUB, OP_MHI};

   always #4 clk = ~clk;

   ncpu_exec_top #(.NUM_LANES(3)) UUT (
      .clk_i        (clk),
      .arst_n_i     (arst_n_i),
      .insn_valid_i (insn_valid_i),
      .insn_i       (insn_i),
      .insn_ready_o (insn_ready_o),
      .wb_valid_o   (wb_valid_o),
      .wb_addr_o    (wb_addr_o),
      .wb_data_o    (wb_data_o),
      .illegal_o    (illegal_o)
   );

   function automatic logic next_bit();
      logic b;
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) begin
         lfsr = lfsr ^ 32'h8020_0003;
      end
      return b;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v = {v[30:0], next_bit()};
      end
      return v;
   endfunction

   function automatic logic [31:0] enc_r(input logic [5:0] opc, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2);
      return {11'h000, rs2, rs1, rd, opc};
   endfunction

   function automatic logic [31:0] enc_i(input logic [5:0] opc, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [15:0] imm);
      return {imm, rs1, rd, opc};
   endfunction

   // Sequential reference of one instruction
   function automatic logic [31:0] ref_result(input logic [5:0] opc, input logic [31:0] a,
                                              input logic [31:0] r2, input logic [15:0] imm);
      logic [31:0] sx;
      logic [31:0] zx;
      sx = {{16{imm[15]}}, imm};
      zx = {16'h0000, imm};
      case (opc)
         OP_AND:   return a & r2;
         OP_AND_I: return a & sx;
         OP_OR:    return a | r2;
         OP_OR_I:  return a | zx;
         OP_XOR:   return a ^ r2;
         OP_XOR_I: return a ^ sx;
         OP_LSL:   return a << r2[4:0];
         OP_LSL_I: return a << imm[4:0];
         OP_LSR:   return a >> r2[4:0];
         OP_LSR_I: return a >> imm[4:0];
         OP_ADD:   return a + r2;
         OP_ADD_I: return a + sx;
         OP_SUB:   return a - r2;
         OP_MUL:   return a * r2;
         OP_MHI:   return {imm, 16'h0000};
         default:  return '0;
      endcase
   endfunction

   function automatic int first_wb(input logic [4:0] addr);
      int pos;
      pos = -1;
      for (int i = wb_log.size() - 1; i >= 0; i--) begin
         if (wb_log[i] == addr) begin
            pos = i;
         end
      end
      return pos;
   endfunction

   task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("[FAIL] %s got %08h exp %08h", name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic add_wb(input int id, input logic [31:0] insn, input logic [31:0] val);
      table_q.push_back('{id, insn, 1'b1, 1'b0, insn[10:6], val});
   endtask

   task automatic add_none(input int id, input logic [31:0] insn, input logic ill);
      table_q.push_back('{id, insn, 1'b0, ill, 5'd0, 32'h0});
   endtask

   task automatic build_table();
      // Immediate forms and MHI
      add_wb(2, enc_i(OP_MHI,   5'd1, 5'd0, 16'h1234), 32'h1234_0000);
      add_wb(2, enc_i(OP_OR_I,  5'd1, 5'd1, 16'h5678), 32'h1234_5678);
      add_wb(2, enc_i(OP_ADD_I, 5'd2, 5'd0, 16'hfff0), 32'hffff_fff0);
      add_wb(2, enc_i(OP_ADD_I, 5'd3, 5'd1, 16'h8000), 32'h1233_d678);
      add_wb(2, enc_i(OP_AND_I, 5'd4, 5'd1, 16'hff00), 32'h1234_5600);
      add_wb(2, enc_i(OP_XOR_I, 5'd5, 5'd1, 16'h00ff), 32'h1234_5687);
      add_wb(2, enc_i(OP_XOR_I, 5'd6, 5'd0, 16'h8001), 32'hffff_8001);
      add_wb(2, enc_i(OP_OR_I,  5'd7, 5'd0, 16'h8001), 32'h0000_8001);
      add_wb(2, enc_i(OP_LSL_I, 5'd8, 5'd7, 16'h0024), 32'h0008_0010);
      add_wb(2, enc_i(OP_LSR_I, 5'd9, 5'd1, 16'h0008), 32'h0012_3456);
      add_none(2, enc_i(OP_ADD_I, 5'd0, 5'd1, 16'h0001), 1'b0);
      // Register forms, r3 and r8 carry high bits above the shift amount
      add_wb(3, enc_r(OP_AND, 5'd10, 5'd1, 5'd2), 32'h1234_5670);
      add_wb(3, enc_r(OP_OR,  5'd11, 5'd1, 5'd7), 32'h1234_d679);
      add_wb(3, enc_r(OP_XOR, 5'd12, 5'd1, 5'd2), 32'hedcb_a988);
      add_wb(3, enc_r(OP_ADD, 5'd13, 5'd1, 5'd2), 32'h1234_5668);
      add_wb(3, enc_r(OP_SUB, 5'd14, 5'd9, 5'd1), 32'heddd_ddde);
      add_wb(3, enc_r(OP_LSL, 5'd15, 5'd7, 5'd3), 32'h0100_0000);
      add_wb(3, enc_r(OP_LSR, 5'd16, 5'd1, 5'd3), 32'h0000_0012);
      add_wb(3, enc_r(OP_LSR, 5'd17, 5'd1, 5'd8), 32'h0000_1234);
      add_wb(3, enc_r(OP_ADD, 5'd18, 5'd0, 5'd1), 32'h1234_5678);
      add_none(3, enc_r(OP_AND, 5'd0, 5'd1, 5'd1), 1'b0);
      add_wb(3, enc_r(OP_SUB, 5'd19, 5'd0, 5'd7), 32'hffff_7fff);
      // MUL overtaken by short ops, then RAW and WAW on r20
      add_wb(4, enc_r(OP_MUL,   5'd20, 5'd7, 5'd9), 32'h1a3d_3456);
      add_wb(4, enc_r(OP_MUL,   5'd21, 5'd2, 5'd2), 32'h0000_0100);
      add_wb(4, enc_i(OP_ADD_I, 5'd22, 5'd0, 16'h0005), 32'h0000_0005);
      add_wb(4, enc_i(OP_OR_I,  5'd23, 5'd0, 16'h0077), 32'h0000_0077);
      add_wb(4, enc_r(OP_ADD,   5'd24, 5'd20, 5'd0), 32'h1a3d_3456);
      add_wb(4, enc_i(OP_ADD_I, 5'd20, 5'd20, 16'h0001), 32'h1a3d_3457);
      add_wb(4, enc_r(OP_MUL,   5'd25, 5'd1, 5'd0), 32'h0000_0000);
      // Illegal opcodes
      add_none(5, enc_r(6'h0a, 5'd27, 5'd1, 5'd2), 1'b1);
      add_wb(5, enc_i(OP_ADD_I, 5'd26, 5'd0, 16'h0011), 32'h0000_0011);
      add_none(5, enc_r(6'h3f, 5'd28, 5'd3, 5'd4), 1'b1);
      add_none(5, enc_r(6'h10, 5'd29, 5'd0, 5'd0), 1'b1);
   endtask

   // Entered and left on a falling edge
   task automatic send(input logic [31:0] insn, input logic wb, input logic [4:0] rd,
                       input logic [31:0] val);
      int n;
      insn_i       = insn;
      insn_valid_i = 1'b1;
      n = 0;
      #2;
      while (!insn_ready_o && n < TIMEOUT) begin
         @(negedge clk);
         #2;
         n++;
      end
      if (!insn_ready_o) begin
         $display("Timeout: instruction %08h not accepted within %0d cycles", insn, TIMEOUT);
         err_cnt++;
      end else if (wb) begin
         exp_wb.push_back({rd, val});
         model_regs[rd] = val;
      end
      @(negedge clk);
      insn_valid_i = 1'b0;
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (exp_wb.size() != 0 && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (exp_wb.size() != 0) begin
         $display("Timeout: %0d expected writebacks never arrived", exp_wb.size());
         err_cnt++;
         exp_wb.delete();
      end
      // Room for stray writebacks longer than a MUL
      repeat (12) @(negedge clk);
   endtask

   task automatic run_table(input int id);
      foreach (table_q[i]) begin
         if (table_q[i].id == id) begin
            send(table_q[i].insn, table_q[i].wb, table_q[i].rd, table_q[i].val);
            if (table_q[i].ill) begin
               ill_exp++;
            end
         end
      end
      drain();
   endtask

   task automatic run_random(input int count);
      logic [5:0]  opc;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [15:0] imm;
      logic [31:0] val;
      int          sel;
      for (int k = 0; k < count; k++) begin
         // Half of the stream is MUL
         if (next_bit()) begin
            opc = OP_MUL;
         end else begin
            sel = int'(rand_bits(4)) % 14;
            opc = short_ops[sel];
         end
         rd  = 5'(rand_bits(5));
         rs1 = 5'(rand_bits(5));
         imm = 16'(rand_bits(16));
         val = ref_result(opc, model_regs[rs1], model_regs[imm[4:0]], imm);
         send({imm, rs1, rd, opc}, rd != 5'd0, rd, val);
      end
      drain();
   endtask

   task automatic check_wb(input logic [4:0] addr, input logic [31:0] data);
      int          hit;
      logic [36:0] ent;
      hit = -1;
      for (int i = 0; i < exp_wb.size(); i++) begin
         ent = exp_wb[i];
         if (hit < 0 && ent[36:32] == addr) begin
            hit = i;
         end
      end
      assert (hit >= 0) else begin
         $display("[FAIL] wb_addr_o got %02h with no write expected to it", addr);
         err_cnt++;
      end
      if (hit >= 0) begin
         ent = exp_wb[hit];
         expect_eq("wb_data_o", data, ent[31:0]);
         exp_wb.delete(hit);
      end
   endtask

   task automatic end_test(input int id, input string name);
      int n;
      n = err_cnt - test_start_err;
      if (n == 0) begin
         $display("test %0d %s: ok", id, name);
      end else begin
         $display("test %0d %s: %0d errors", id, name, n);
         tests_failed++;
      end
      tests_run++;
      test_start_err = err_cnt;
   endtask

   // Registered outputs, stable at the falling edge
   always @(negedge clk) begin
      if (arst_n_i && wb_valid_o) begin
         wb_log.push_back(wb_addr_o);
         check_wb(wb_addr_o, wb_data_o);
      end
      if (arst_n_i && illegal_o) begin
         ill_seen++;
      end
   end

   initial begin
      insn_valid_i = 1'b0;
      insn_i       = '0;
      arst_n_i     = 1'b0;
      lfsr         = 32'h642f_2219;
      for (int r = 0; r < 32; r++) begin
         model_regs[r] = '0;
      end
      build_table();
      repeat (8) begin
         @(negedge clk);
         expect_eq("insn_ready_o", 32'(insn_ready_o), 32'h0);
         expect_eq("wb_valid_o", 32'(wb_valid_o), 32'h0);
         expect_eq("illegal_o", 32'(illegal_o), 32'h0);
      end
      arst_n_i = 1'b1;
      end_test(1, "reset");
      run_table(2);
      end_test(2, "immediate forms");
      run_table(3);
      end_test(3, "register forms");
      wb_log.delete();
      run_table(4);
      assert (first_wb(5'd22) >= 0 && first_wb(5'd20) > first_wb(5'd22)) else begin
         $display("MUL result on r20 did not arrive after the independent result on r22");
         err_cnt++;
      end
      end_test(4, "multiply ordering");
      run_table(5);
      expect_eq("illegal_o pulse count", ill_seen, ill_exp);
      end_test(5, "illegal opcodes");
      run_random(40);
      end_test(6, "random stream");
      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
      if (err_cnt == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: all.f
hdl/ncpu_pkg.sv
hdl/ncpu_if.sv
hdl/ncpu_regfile.sv
hdl/ncpu_idu.sv
hdl/ncpu_dispatch.sv
hdl/ncpu_alu_lane.sv
hdl/ncpu_wb_arb.sv
hdl/ncpu_exec_top.sv
verif/ncpu_exec_chk.sv
verif/ncpu_exec_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module ncpu_exec_tb -f all.f -o Vncpu_exec_tb

./obj_dir/Vncpu_exec_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log || ! grep -q "Regression passed" sim.log; then
   echo "simulation FAILED, see sim.log"
   exit 1
fi
echo "simulation ok"
